/* design/cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// One-bit logic levels
`define ENABLE              1'b1
`define DISABLE             1'b0

// Widths fixed by the ISA
`define WORD_WIDTH          32
`define INST_ADDR_WIDTH     32
`define STALL_WIDTH         6
`define EXCP_WIDTH          4

// Stall vectors, bit 0 is the PC and bit 5 write-back
`define STALL_NONE          6'b000000
`define STALL_BUS           6'b111111
`define STALL_EX            6'b001111
`define STALL_ID            6'b000111

// Boot ROM entry in kseg1
`define PC_RESET_ADDR       32'hBFC0_0000

// Exception vectors, BEV set so all sit in the boot region
`define PC_TLB_REFILL       32'hBFC0_0200
`define PC_SYSCALL          32'hBFC0_0380
`define PC_INTERRUPT        32'hBFC0_0400   // Dedicated interrupt vector
`define PC_INVALID_INST     32'hBFC0_0480
`define PC_OV               32'hBFC0_0500
`define PC_TLB_INVALID      32'hBFC0_0580

// Sequential fetch step in bytes
`define PC_STEP             32'd4

`endif

/* design/excp_pkg.sv */
`default_nettype none

package excp_pkg;

    // Exception codes carried from execute to the memory stage
    typedef enum logic [3:0] {
        EXC_NO                     = 4'd0,
        EXC_INTERRUPT              = 4'd1,
        EXC_SYSCALL                = 4'd2,
        EXC_INVALID_INST           = 4'd3,
        EXC_OV                     = 4'd4,
        EXC_INST_TLB_REFILL        = 4'd5,
        EXC_DATA_TLB_REFILL_LOAD   = 4'd6,
        EXC_DATA_TLB_REFILL_STORE  = 4'd7,
        EXC_INST_TLB_INVALID       = 4'd8,
        EXC_DATA_TLB_INVALID_LOAD  = 4'd9,
        EXC_DATA_TLB_INVALID_STORE = 4'd10,
        EXC_ERET                   = 4'd11   // Return from handler, not a fault
    } Excp_t;

endpackage

`default_nettype wire

/* design/cpu_types_pkg.sv */
`default_nettype none

`include "cpu_defs.svh"

package cpu_types_pkg;

    typedef logic                          Bit_t;
    typedef logic [`WORD_WIDTH-1:0]        Word_t;
    typedef logic [`INST_ADDR_WIDTH-1:0]   Inst_addr_t;
    typedef logic [`STALL_WIDTH-1:0]       Stall_t;

    // Valid must stay the top field, stage_reg bubbles by clearing the MSB
    typedef struct packed {
        Bit_t       valid;
        Inst_addr_t pc;
    } stage_tag_t;

    // Execute onward also carries an exception code
    typedef struct packed {
        Bit_t            valid;
        Inst_addr_t      pc;
        excp_pkg::Excp_t excp;
    } excp_tag_t;

endpackage

`default_nettype wire

/* design/ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module ctrl (
    input  cpu_types_pkg::Bit_t       rst,
    input  cpu_types_pkg::Bit_t       stallreq_from_bus,
    input  cpu_types_pkg::Bit_t       stallreq_from_id,
    input  cpu_types_pkg::Bit_t       stallreq_from_ex,
    output cpu_types_pkg::Stall_t     stall,

    input  cpu_types_pkg::Word_t      cp0_epc_i,
    input  excp_pkg::Excp_t           exception_type_i,
    output cpu_types_pkg::Inst_addr_t new_pc,
    output cpu_types_pkg::Bit_t       flush
);

    // Priority: reset, exception, bus, execute, decode
    always_comb begin
        stall  = `STALL_NONE;
        flush  = `DISABLE;
        new_pc = `PC_RESET_ADDR;   // Don't care unless flush is raised

        if (rst == `ENABLE) begin
            stall = `STALL_NONE;
        end else if (exception_type_i != excp_pkg::EXC_NO) begin
            flush = `ENABLE;   // Whole pipe is squashed, nothing held
            case (exception_type_i)
                excp_pkg::EXC_INTERRUPT: begin
                    new_pc = `PC_INTERRUPT;
                end
                excp_pkg::EXC_SYSCALL: begin
                    new_pc = `PC_SYSCALL;
                end
                excp_pkg::EXC_INVALID_INST: begin
                    new_pc = `PC_INVALID_INST;
                end
                excp_pkg::EXC_OV: begin
                    new_pc = `PC_OV;
                end
                excp_pkg::EXC_INST_TLB_REFILL,
                excp_pkg::EXC_DATA_TLB_REFILL_LOAD,
                excp_pkg::EXC_DATA_TLB_REFILL_STORE: begin
                    new_pc = `PC_TLB_REFILL;
                end
                excp_pkg::EXC_INST_TLB_INVALID,
                excp_pkg::EXC_DATA_TLB_INVALID_LOAD,
                excp_pkg::EXC_DATA_TLB_INVALID_STORE: begin
                    new_pc = `PC_TLB_INVALID;
                end
                excp_pkg::EXC_ERET: begin
                    new_pc = cp0_epc_i;   // Back to the faulting instruction
                end
                default: begin
                    new_pc = `PC_RESET_ADDR;
                end
            endcase
        end else if (stallreq_from_bus == `ENABLE) begin
            stall = `STALL_BUS;
        end else if (stallreq_from_ex == `ENABLE) begin
            stall = `STALL_EX;
        end else if (stallreq_from_id == `ENABLE) begin
            stall = `STALL_ID;
        end else begin
            stall = `STALL_NONE;
        end
    end

endmodule

`default_nettype wire

/* design/pc_reg.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module pc_reg (
    input  logic                      clk,
    input  logic                      reset,
    input  cpu_types_pkg::Stall_t     stall,
    input  cpu_types_pkg::Bit_t       flush,
    input  cpu_types_pkg::Inst_addr_t new_pc,
    output cpu_types_pkg::Inst_addr_t pc
);

    cpu_types_pkg::Inst_addr_t pc_next;

    // Redirect wins over stall, ctrl never raises both
    always_comb begin
        if (flush == `ENABLE) begin
            pc_next = new_pc;
        end else if (stall[0] == `ENABLE) begin
            pc_next = pc;
        end else begin
            pc_next = pc + `PC_STEP;
        end
    end

    always_ff @(posedge clk) begin
        if (reset == `ENABLE) begin
            pc <= `PC_RESET_ADDR;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

`default_nettype wire

/* design/stage_reg.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

// Pipeline register for any payload whose MSB is the valid flag
module stage_reg #(
    parameter type payload_t = logic [1:0]
) (
    input  logic                clk,
    input  logic                reset,
    input  cpu_types_pkg::Bit_t stall_self,
    input  cpu_types_pkg::Bit_t stall_next,
    input  cpu_types_pkg::Bit_t flush,
    input  payload_t            d,
    output payload_t            q
);

    localparam int W = $bits(payload_t);

    logic [W-1:0] q_r;
    logic         bubble;

    // This stage stalls but the next one moves on
    assign bubble = (stall_self == `ENABLE) && (stall_next == `DISABLE);

    always_ff @(posedge clk) begin
        if ((reset == `ENABLE) || (flush == `ENABLE)) begin
            q_r[W-1] <= `DISABLE;   // Only valid is cleared, the rest is don't care
        end else if (bubble) begin
            q_r[W-1] <= `DISABLE;
        end else if (stall_self == `DISABLE) begin
            q_r <= d;
        end
        // Otherwise hold the current tag
    end

    assign q = payload_t'(q_r);

endmodule

`default_nettype wire

/* design/excp_resolve.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module excp_resolve (
    input  logic                     clk,
    input  logic                     reset,
    input  cpu_types_pkg::excp_tag_t mem_tag,
    input  cpu_types_pkg::Bit_t      int_req,
    output excp_pkg::Excp_t          exception_type,
    output cpu_types_pkg::Word_t     cp0_epc
);

    cpu_types_pkg::Bit_t exl;        // Status.EXL, masks interrupts in the handler
    logic                int_taken;
    logic                excp_taken;
    logic                eret_taken;

    // Interrupt is charged to the instruction sitting in memory
    assign int_taken = (int_req == `ENABLE) && (exl == `DISABLE)
                       && (mem_tag.valid == `ENABLE);

    always_comb begin
        exception_type = excp_pkg::EXC_NO;
        if (int_taken) begin
            exception_type = excp_pkg::EXC_INTERRUPT;
        end else if (mem_tag.valid == `ENABLE) begin
            exception_type = mem_tag.excp;
        end
    end

    assign eret_taken = (exception_type == excp_pkg::EXC_ERET);
    assign excp_taken = (exception_type != excp_pkg::EXC_NO) && !eret_taken;

    always_ff @(posedge clk) begin
        if (reset == `ENABLE) begin
            exl <= `DISABLE;
        end else if (eret_taken) begin
            exl <= `DISABLE;
        end else if (excp_taken) begin
            exl <= `ENABLE;
        end
    end

    // EPC points at the faulting instruction so it is retried after ERET
    always_ff @(posedge clk) begin
        if ((reset == `DISABLE) && excp_taken) begin
            cp0_epc <= mem_tag.pc;
        end
    end

endmodule

`default_nettype wire

/* design/pipe_ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module pipe_ctrl_top (
    input  logic                      clk,
    input  logic                      reset,
    input  cpu_types_pkg::Bit_t       stallreq_from_bus,
    input  cpu_types_pkg::Bit_t       stallreq_from_id,
    input  cpu_types_pkg::Bit_t       stallreq_from_ex,
    input  excp_pkg::Excp_t           ex_excp,
    input  cpu_types_pkg::Bit_t       int_req,
    output cpu_types_pkg::Inst_addr_t pc,
    output cpu_types_pkg::Stall_t     stall,
    output cpu_types_pkg::Bit_t       flush,
    output cpu_types_pkg::Bit_t       wb_valid,
    output cpu_types_pkg::Inst_addr_t wb_pc,
    output excp_pkg::Excp_t           wb_excp
);

    cpu_types_pkg::Inst_addr_t new_pc;
    cpu_types_pkg::Word_t      cp0_epc;
    excp_pkg::Excp_t           exception_type;

    cpu_types_pkg::stage_tag_t if_tag;     // Fetch
    cpu_types_pkg::stage_tag_t id_tag;     // Decode
    cpu_types_pkg::stage_tag_t ex_tag;     // Execute
    cpu_types_pkg::excp_tag_t  ex_out;     // Execute tag with its exception code
    cpu_types_pkg::excp_tag_t  mem_tag;    // Memory
    cpu_types_pkg::excp_tag_t  wb_tag;     // Write-back

    assign if_tag.valid = ~reset;
    assign if_tag.pc    = pc;

    assign ex_out.valid = ex_tag.valid;
    assign ex_out.pc    = ex_tag.pc;
    assign ex_out.excp  = ex_excp;

    ctrl u_ctrl (
        .rst               (reset),
        .stallreq_from_bus (stallreq_from_bus),
        .stallreq_from_id  (stallreq_from_id),
        .stallreq_from_ex  (stallreq_from_ex),
        .stall             (stall),
        .cp0_epc_i         (cp0_epc),
        .exception_type_i  (exception_type),
        .new_pc            (new_pc),
        .flush             (flush)
    );

    pc_reg u_pc_reg (
        .clk    (clk),
        .reset  (reset),
        .stall  (stall),
        .flush  (flush),
        .new_pc (new_pc),
        .pc     (pc)
    );

    stage_reg #(.payload_t(cpu_types_pkg::stage_tag_t)) u_if_id (
        .clk        (clk),
        .reset      (reset),
        .stall_self (stall[1]),
        .stall_next (stall[2]),
        .flush      (flush),
        .d          (if_tag),
        .q          (id_tag)
    );

    stage_reg #(.payload_t(cpu_types_pkg::stage_tag_t)) u_id_ex (
        .clk        (clk),
        .reset      (reset),
        .stall_self (stall[2]),
        .stall_next (stall[3]),
        .flush      (flush),
        .d          (id_tag),
        .q          (ex_tag)
    );

    stage_reg #(.payload_t(cpu_types_pkg::excp_tag_t)) u_ex_mem (
        .clk        (clk),
        .reset      (reset),
        .stall_self (stall[3]),
        .stall_next (stall[4]),
        .flush      (flush),
        .d          (ex_out),
        .q          (mem_tag)
    );

    // Nothing follows write-back, so a bus stall drains it as a bubble
    stage_reg #(.payload_t(cpu_types_pkg::excp_tag_t)) u_mem_wb (
        .clk        (clk),
        .reset      (reset),
        .stall_self (stall[5]),
        .stall_next (`DISABLE),
        .flush      (flush),
        .d          (mem_tag),
        .q          (wb_tag)
    );

    excp_resolve u_excp_resolve (
        .clk            (clk),
        .reset          (reset),
        .mem_tag        (mem_tag),
        .int_req        (int_req),
        .exception_type (exception_type),
        .cp0_epc        (cp0_epc)
    );

    assign wb_valid = wb_tag.valid;
    assign wb_pc    = wb_tag.pc;
    assign wb_excp  = wb_tag.excp;

endmodule

`default_nettype wire

/* bench/clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

// Free-running clock for the testbench
module clock_gen #(
    parameter int HALF_PERIOD_NS = 10   // 20 ns period
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(HALF_PERIOD_NS) clk = ~clk;

endmodule

`default_nettype wire

/* bench/pipe_ctrl_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module pipe_ctrl_tb;

    localparam int SEQ_CYCLES  = 40;
    localparam int RAND_CYCLES = 900;
    localparam int MAX_CYCLES  = 2000;   // Whole sequence runs close to 1200 cycles

    localparam logic [1:0] LOAD   = 2'd0;
    localparam logic [1:0] HOLD   = 2'd1;
    localparam logic [1:0] BUBBLE = 2'd2;

    logic            clk;
    logic            reset;
    logic            stallreq_from_bus;
    logic            stallreq_from_id;
    logic            stallreq_from_ex;
    excp_pkg::Excp_t ex_excp;
    logic            int_req;
    logic [31:0]     pc;
    logic [5:0]      stall;
    logic            flush;
    logic            wb_valid;
    logic [31:0]     wb_pc;
    excp_pkg::Excp_t wb_excp;

    integer seed;
    int     r;
    int     errors;
    int     cycle_count;
    int     flush_count;

    // Model of the PC, CP0 and the stage tags
    logic [31:0]     m_pc;
    logic [31:0]     m_epc;
    logic            m_exl;
    logic [31:0]     next_retire;   // Write-back must retire in program order
    logic            m_id_v;
    logic [31:0]     m_id_pc;
    logic            m_ex_v;
    logic [31:0]     m_ex_pc;
    logic            m_mem_v;
    logic [31:0]     m_mem_pc;
    excp_pkg::Excp_t m_mem_x;
    logic            m_wb_v;
    logic [31:0]     m_wb_pc;
    excp_pkg::Excp_t m_wb_x;

    excp_pkg::Excp_t fault_codes [10] = '{
        excp_pkg::EXC_INTERRUPT, excp_pkg::EXC_SYSCALL, excp_pkg::EXC_INVALID_INST,
        excp_pkg::EXC_OV, excp_pkg::EXC_INST_TLB_REFILL,
        excp_pkg::EXC_DATA_TLB_REFILL_LOAD, excp_pkg::EXC_DATA_TLB_REFILL_STORE,
        excp_pkg::EXC_INST_TLB_INVALID, excp_pkg::EXC_DATA_TLB_INVALID_LOAD,
        excp_pkg::EXC_DATA_TLB_INVALID_STORE
    };

    clock_gen u_clock_gen (
        .clk (clk)
    );

    pipe_ctrl_top DUT (
        .clk               (clk),
        .reset             (reset),
        .stallreq_from_bus (stallreq_from_bus),
        .stallreq_from_id  (stallreq_from_id),
        .stallreq_from_ex  (stallreq_from_ex),
        .ex_excp           (ex_excp),
        .int_req           (int_req),
        .pc                (pc),
        .stall             (stall),
        .flush             (flush),
        .wb_valid          (wb_valid),
        .wb_pc             (wb_pc),
        .wb_excp           (wb_excp)
    );

    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        if (got !== exp) begin
            errors = errors + 1;
            $display("Error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    // Expected {stall, flush, new_pc} for one cycle out of reset
    function automatic logic [38:0] expected_ctrl(input logic bus, input logic id,
                                                  input logic ex, input excp_pkg::Excp_t exc,
                                                  input logic [31:0] epc);
        logic [5:0]  st;
        logic        fl;
        logic [31:0] npc;
        st  = 6'b000000;
        fl  = 1'b0;
        npc = `PC_RESET_ADDR;
        if (exc != excp_pkg::EXC_NO) begin
            fl = 1'b1;
            case (exc)
                excp_pkg::EXC_INTERRUPT:    npc = `PC_INTERRUPT;
                excp_pkg::EXC_SYSCALL:      npc = `PC_SYSCALL;
                excp_pkg::EXC_INVALID_INST: npc = `PC_INVALID_INST;
                excp_pkg::EXC_OV:           npc = `PC_OV;
                excp_pkg::EXC_ERET:         npc = epc;
                excp_pkg::EXC_INST_TLB_REFILL,
                excp_pkg::EXC_DATA_TLB_REFILL_LOAD,
                excp_pkg::EXC_DATA_TLB_REFILL_STORE: npc = `PC_TLB_REFILL;
                default:                    npc = `PC_TLB_INVALID;
            endcase
        end else if (bus) begin
            st = 6'b111111;
        end else if (ex) begin
            st = 6'b001111;
        end else if (id) begin
            st = 6'b000111;
        end
        return {st, fl, npc};
    endfunction

    function automatic logic [1:0] stage_step(input logic self_stall, input logic next_stall);
        if (self_stall && !next_stall) begin
            return BUBBLE;
        end else if (self_stall) begin
            return HOLD;
        end
        return LOAD;
    endfunction

    // Compare against the model on every rising edge, then step the model
    always @(posedge clk) begin
        logic [38:0]     exp_ctrl;
        logic [5:0]      st;
        excp_pkg::Excp_t exc;
        if (reset) begin
            m_pc        = `PC_RESET_ADDR;
            next_retire = `PC_RESET_ADDR;
            m_exl       = 1'b0;
            m_id_v      = 1'b0;
            m_ex_v      = 1'b0;
            m_mem_v     = 1'b0;
            m_wb_v      = 1'b0;
        end else begin
            check_eq("pc", pc, m_pc);
            check_eq("wb_valid", 32'(wb_valid), 32'(m_wb_v));
            if (m_wb_v) begin
                check_eq("wb_pc", wb_pc, m_wb_pc);
                check_eq("wb_excp", 32'(wb_excp), 32'(m_wb_x));
                check_eq("wb_pc order", wb_pc, next_retire);
                next_retire = next_retire + 32'd4;
            end
            if (int_req && !m_exl && m_mem_v) begin
                exc = excp_pkg::EXC_INTERRUPT;
            end else if (m_mem_v) begin
                exc = m_mem_x;
            end else begin
                exc = excp_pkg::EXC_NO;
            end
            exp_ctrl = expected_ctrl(stallreq_from_bus, stallreq_from_id, stallreq_from_ex,
                                     exc, m_epc);
            st = exp_ctrl[38:33];
            check_eq("stall", 32'(stall), 32'(st));
            check_eq("flush", 32'(flush), 32'(exp_ctrl[32]));
            if (exc == excp_pkg::EXC_ERET) begin
                m_exl = 1'b0;
            end else if (exc != excp_pkg::EXC_NO) begin
                m_exl = 1'b1;
                m_epc = m_mem_pc;
            end
            if (exp_ctrl[32]) begin
                m_pc        = exp_ctrl[31:0];
                next_retire = exp_ctrl[31:0];
                m_id_v      = 1'b0;
                m_ex_v      = 1'b0;
                m_mem_v     = 1'b0;
                m_wb_v      = 1'b0;
            end else begin
                // Stepped back to front so each stage reads the old tag ahead of it
                case (stage_step(st[5], 1'b0))
                    BUBBLE: m_wb_v = 1'b0;
                    LOAD: begin
                        m_wb_v  = m_mem_v;
                        m_wb_pc = m_mem_pc;
                        m_wb_x  = m_mem_x;
                    end
                    default: ;
                endcase
                case (stage_step(st[3], st[4]))
                    BUBBLE: m_mem_v = 1'b0;
                    LOAD: begin
                        m_mem_v  = m_ex_v;
                        m_mem_pc = m_ex_pc;
                        m_mem_x  = ex_excp;
                    end
                    default: ;
                endcase
                case (stage_step(st[2], st[3]))
                    BUBBLE: m_ex_v = 1'b0;
                    LOAD: begin
                        m_ex_v  = m_id_v;
                        m_ex_pc = m_id_pc;
                    end
                    default: ;
                endcase
                case (stage_step(st[1], st[2]))
                    BUBBLE: m_id_v = 1'b0;
                    LOAD: begin
                        m_id_v  = 1'b1;   // Fetch tag is valid out of reset
                        m_id_pc = m_pc;
                    end
                    default: ;
                endcase
                if (!st[0]) begin
                    m_pc = m_pc + 32'd4;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Errors found");
            $fatal(1);
        end
    end

    task automatic wait_for_flush(input int limit);
        int waited;
        waited = 0;
        @(posedge clk);
        while (flush !== 1'b1) begin
            waited = waited + 1;
            if (waited > limit) begin
                $display("Flush did not rise within %0d cycles at %0d ns", limit, $time);
                $display("Errors found");
                $fatal(1);
            end
            @(posedge clk);
        end
    endtask

    // Tags the instruction in execute with a code for one cycle
    task automatic raise_excp(input excp_pkg::Excp_t code);
        repeat (5) @(negedge clk);
        ex_excp = code;
        @(negedge clk);
        ex_excp = excp_pkg::EXC_NO;
        wait_for_flush(4);
    endtask

    initial begin
        seed              = 32'he14a_3f46;
        errors            = 0;
        cycle_count       = 0;
        flush_count       = 0;
        reset             = 1'b1;
        stallreq_from_bus = 1'b0;
        stallreq_from_id  = 1'b0;
        stallreq_from_ex  = 1'b0;
        ex_excp           = excp_pkg::EXC_NO;
        int_req           = 1'b0;
        repeat (8) @(negedge clk);
        reset = 1'b0;

        repeat (SEQ_CYCLES) @(negedge clk);   // Plain sequential fetch

        repeat (RAND_CYCLES) begin
            @(negedge clk);
            r = $random(seed);
            stallreq_from_bus = (r[2:0] == 3'd0);
            stallreq_from_ex  = (r[5:4] == 2'd0);
            stallreq_from_id  = (r[9:8] == 2'd0);
        end
        @(negedge clk);
        stallreq_from_bus = 1'b0;
        stallreq_from_ex  = 1'b0;
        stallreq_from_id  = 1'b0;
        repeat (10) @(negedge clk);

        foreach (fault_codes[i]) begin
            raise_excp(fault_codes[i]);
            raise_excp(excp_pkg::EXC_ERET);   // Back to the faulting pc
        end

        @(negedge clk);
        int_req = 1'b1;
        wait_for_flush(10);
        repeat (30) begin
            @(posedge clk);
            if (flush === 1'b1) begin
                flush_count = flush_count + 1;
            end
        end
        check_eq("flush count with EXL set", 32'(flush_count), 32'd0);
        raise_excp(excp_pkg::EXC_ERET);
        wait_for_flush(10);   // Interrupt unmasked again
        @(negedge clk);
        int_req = 1'b0;

        repeat (10) @(negedge clk);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* mips_pipe.f */
+incdir+design
design/excp_pkg.sv
design/cpu_types_pkg.sv
design/ctrl.sv
design/pc_reg.sv
design/stage_reg.sv
design/excp_resolve.sv
design/pipe_ctrl_top.sv
bench/clock_gen.sv
bench/pipe_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, then search the log for the fail message

verilator --binary --timing -f mips_pipe.f --top-module pipe_ctrl_tb -o pipe_ctrl_sim \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/pipe_ctrl_sim > sim.log 2>&1
cat sim.log

grep -q "Errors found" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "No errors" sim.log || { echo "Simulation ended early"; exit 1; }
echo "Simulation passed"
